//--- l2mem.f
+incdir+.
l2mem_pkg.sv
l2mem_line_ram.sv
l2mem_port_mux.sv
l2mem_cfg_regs.sv
l2mem_top.sv
tb_l2mem_top.sv

//--- Bender.yml
package:
  name: l2mem

sources:
  - include_dirs:
      - .
    files:
      - l2mem_pkg.sv
      - l2mem_line_ram.sv
      - l2mem_port_mux.sv
      - l2mem_cfg_regs.sv
      - l2mem_top.sv
      - target: test
        files:
          - tb_l2mem_top.sv

//--- tb_l2mem_top.sv
`timescale 1ns/1ps
`include "l2mem_params.svh"

module tb_l2mem_top;

  import l2mem_pkg::*;

  localparam int LAT    = `L2MEM_RD_LAT;
  localparam int OFFS_W = $clog2(`L2MEM_DATA_W / 8);
  localparam int RSP_W  = `L2MEM_TAG_W + `L2MEM_DATA_W + 1;
  localparam int STIM_W = 2 + `L2MEM_ADDR_W + `L2MEM_TAG_W + `L2MEM_DATA_W + `L2MEM_BE_W;

  // Lines in use must stay a power of two
  localparam int N_FILL  = 16;
  localparam int N_LAT   = 12;
  localparam int N_BP    = 30;
  localparam int N_RAND  = 25;
  localparam int N_OOR   = 4;
  localparam int N_REG   = 12;
  localparam int N_IDLE  = 6;
  localparam int NUM_TXN = 3 * N_FILL + N_LAT + N_BP + 2 * N_RAND + N_OOR + N_REG + N_IDLE;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     ic_req_valid;
  logic                     dc_req_valid;
  mem_cmd_t                 ic_req_cmd;
  mem_cmd_t                 dc_req_cmd;
  logic [`L2MEM_ADDR_W-1:0] ic_req_addr;
  logic [`L2MEM_ADDR_W-1:0] dc_req_addr;
  logic [`L2MEM_TAG_W-1:0]  ic_req_tag;
  logic [`L2MEM_TAG_W-1:0]  dc_req_tag;
  logic [`L2MEM_DATA_W-1:0] ic_req_data;
  logic [`L2MEM_DATA_W-1:0] dc_req_data;
  logic [`L2MEM_BE_W-1:0]   ic_req_byte_en;
  logic [`L2MEM_BE_W-1:0]   dc_req_byte_en;
  logic                     o_ic_req_ready;
  logic                     o_dc_req_ready;
  logic                     o_ic_resp_valid;
  logic                     o_dc_resp_valid;
  logic [`L2MEM_TAG_W-1:0]  o_ic_resp_tag;
  logic [`L2MEM_TAG_W-1:0]  o_dc_resp_tag;
  logic [`L2MEM_DATA_W-1:0] o_ic_resp_data;
  logic [`L2MEM_DATA_W-1:0] o_dc_resp_data;
  logic                     o_ic_resp_err;
  logic                     o_dc_resp_err;
  logic                     ic_resp_ready;
  logic                     dc_resp_ready;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [1:0]               wb_adr;
  logic [31:0]              wb_dat;
  logic [31:0]              o_wb_dat;
  logic                     o_wb_ack;

  integer                   seed = 32'hd4e0_1e49;
  int                       cycle;
  int                       ack_count;
  logic                     check_latency;
  logic                     bp_random;
  logic                     expect_disabled;
  logic                     last_was_ic;
  logic [`L2MEM_ADDR_W-1:0] base_model;

  // Reference memory and expected responses per port (0 = ic, 1 = dc)
  logic [`L2MEM_DATA_W-1:0] model [int];
  logic [RSP_W-1:0]         exp_q [2][$];
  int                       acc_q [2][$];
  logic                     prev_stall [2];
  logic [RSP_W-1:0]         prev_rsp [2];
  logic [STIM_W-1:0]        stim_q [2][$];

  l2mem_top i_dut (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_ic_req_valid   (ic_req_valid),
    .i_ic_req_cmd     (ic_req_cmd),
    .i_ic_req_addr    (ic_req_addr),
    .i_ic_req_tag     (ic_req_tag),
    .i_ic_req_data    (ic_req_data),
    .i_ic_req_byte_en (ic_req_byte_en),
    .o_ic_req_ready   (o_ic_req_ready),
    .o_ic_resp_valid  (o_ic_resp_valid),
    .o_ic_resp_tag    (o_ic_resp_tag),
    .o_ic_resp_data   (o_ic_resp_data),
    .o_ic_resp_err    (o_ic_resp_err),
    .i_ic_resp_ready  (ic_resp_ready),
    .i_dc_req_valid   (dc_req_valid),
    .i_dc_req_cmd     (dc_req_cmd),
    .i_dc_req_addr    (dc_req_addr),
    .i_dc_req_tag     (dc_req_tag),
    .i_dc_req_data    (dc_req_data),
    .i_dc_req_byte_en (dc_req_byte_en),
    .o_dc_req_ready   (o_dc_req_ready),
    .o_dc_resp_valid  (o_dc_resp_valid),
    .o_dc_resp_tag    (o_dc_resp_tag),
    .o_dc_resp_data   (o_dc_resp_data),
    .o_dc_resp_err    (o_dc_resp_err),
    .i_dc_resp_ready  (dc_resp_ready),
    .i_wb_cyc         (wb_cyc),
    .i_wb_stb         (wb_stb),
    .i_wb_we          (wb_we),
    .i_wb_adr         (wb_adr),
    .i_wb_dat         (wb_dat),
    .o_wb_dat         (o_wb_dat),
    .o_wb_ack         (o_wb_ack)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  initial begin
    repeat (NUM_TXN * (LAT + 20)) @(posedge i_clk);
    $display("Watchdog expired before all tests completed");
    $display("Regression failed");
    $fatal(1);
  end

  task automatic mismatch(input string name, input logic [127:0] exp, input logic [127:0] act);
    $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Region covers LINES lines of BE_W bytes upward from the base
  function automatic logic out_of_region(input logic [`L2MEM_ADDR_W-1:0] addr);
    return (addr < base_model) || (addr - base_model >= `L2MEM_LINES * `L2MEM_BE_W);
  endfunction

  property one_port_ready;
    @(posedge i_clk) disable iff (!i_reset_n) !(o_ic_req_ready && o_dc_req_ready);
  endproperty

  assert property (one_port_ready)
    else abort_run("Both request ports were ready in the same cycle");

  // Model update in acceptance order, grant order and response checks
  always @(posedge i_clk) begin : monitor
    logic                     fire [2];
    logic                     v;
    logic                     r;
    logic [RSP_W-1:0]         cur;
    logic [RSP_W-1:0]         exp;
    logic [`L2MEM_ADDR_W-1:0] addr;
    logic [`L2MEM_DATA_W-1:0] data;
    logic [`L2MEM_BE_W-1:0]   be;
    logic                     bad;
    int                       line;
    int                       acc;
    if (i_reset_n) begin
      fire[0] = ic_req_valid && o_ic_req_ready;
      fire[1] = dc_req_valid && o_dc_req_ready;
      if (expect_disabled) begin
        assert (!o_ic_req_ready && !o_dc_req_ready)
          else abort_run("A request port was ready while the memory was disabled");
      end
      if (ic_req_valid && dc_req_valid && (fire[0] || fire[1])) begin
        assert (fire[1] == last_was_ic)
          else mismatch("grant_alternation", last_was_ic, fire[1]);
      end
      for (int p = 0; p < 2; p++) begin
        if (fire[p]) begin
          addr = p ? dc_req_addr : ic_req_addr;
          data = p ? dc_req_data : ic_req_data;
          be   = p ? dc_req_byte_en : ic_req_byte_en;
          bad  = out_of_region(addr);
          line = int'((addr - base_model) >> OFFS_W);
          if ((p ? dc_req_cmd : ic_req_cmd) == M_XWR) begin
            if (!bad) begin
              for (int b = 0; b < `L2MEM_BE_W; b++) begin
                if (be[b]) model[line][b*8 +: 8] = data[b*8 +: 8];
              end
            end
          end else begin
            exp_q[p].push_back({p ? dc_req_tag : ic_req_tag,
                                bad ? `L2MEM_DATA_W'(0) : model[line], bad});
            acc_q[p].push_back(cycle);
          end
          last_was_ic = (p == 0);
        end
        v   = p ? o_dc_resp_valid : o_ic_resp_valid;
        r   = p ? dc_resp_ready : ic_resp_ready;
        cur = p ? {o_dc_resp_tag, o_dc_resp_data, o_dc_resp_err}
                : {o_ic_resp_tag, o_ic_resp_data, o_ic_resp_err};
        if (prev_stall[p]) begin
          assert (v && cur === prev_rsp[p])
            else mismatch("resp_stable", {1'b1, prev_rsp[p]}, {v, cur});
        end
        if (v && r) begin
          if (exp_q[p].size() == 0) begin
            abort_run($sformatf("Port %0d returned a response nobody asked for", p));
          end else begin
            exp = exp_q[p].pop_front();
            acc = acc_q[p].pop_front();
            assert (cur === exp) else mismatch("resp_match", exp, cur);
            if (check_latency) begin
              assert (cycle - acc == LAT) else mismatch("read_latency", LAT, cycle - acc);
            end
          end
        end
        prev_stall[p] = v && !r;
        prev_rsp[p]   = cur;
      end
      if (o_wb_ack) ack_count++;
      cycle++;
    end
  end

  // Response back-pressure is random only when enabled
  always @(posedge i_clk) begin : backpressure
    logic [1:0] rdy;
    rdy = bp_random ? 2'($random(seed)) : 2'b11;
    #1;
    ic_resp_ready <= rdy[0];
    dc_resp_ready <= rdy[1];
  end

  task automatic wb_access(input logic we, input reg_addr_t adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    int acks_before;
    acks_before = ack_count;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat;
    @(posedge i_clk);
    while (!o_wb_ack) @(posedge i_clk);
    rdata = o_wb_dat;
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge i_clk);
    #1;
    assert (ack_count == acks_before + 1)
      else mismatch("wb_single_ack", acks_before + 1, ack_count);
  endtask

  task automatic reg_check(input string name, input reg_addr_t adr, input logic [31:0] exp);
    logic [31:0] rdata;
    wb_access(1'b0, adr, 32'h0, rdata);
    assert (rdata === exp) else mismatch(name, exp, rdata);
  endtask

  task automatic reg_write(input reg_addr_t adr, input logic [31:0] dat);
    logic [31:0] rdata;
    wb_access(1'b1, adr, dat, rdata);
    if (adr == REG_BASE) base_model = dat;
  endtask

  // Called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send_req(input int p, input mem_cmd_t cmd,
                          input logic [`L2MEM_ADDR_W-1:0] addr,
                          input logic [`L2MEM_TAG_W-1:0] tag,
                          input logic [`L2MEM_DATA_W-1:0] data,
                          input logic [`L2MEM_BE_W-1:0] be);
    if (p == 0) begin
      ic_req_cmd     = cmd;
      ic_req_addr    = addr;
      ic_req_tag     = tag;
      ic_req_data    = data;
      ic_req_byte_en = be;
      ic_req_valid   = 1'b1;
    end else begin
      dc_req_cmd     = cmd;
      dc_req_addr    = addr;
      dc_req_tag     = tag;
      dc_req_data    = data;
      dc_req_byte_en = be;
      dc_req_valid   = 1'b1;
    end
    @(posedge i_clk);
    while (!(p ? o_dc_req_ready : o_ic_req_ready)) @(posedge i_clk);
    #1;
    if (p == 0) ic_req_valid = 1'b0;
    else dc_req_valid = 1'b0;
  endtask

  function automatic logic [`L2MEM_ADDR_W-1:0] line_addr(input int line);
    return base_model + (line << OFFS_W);
  endfunction

  function automatic logic [`L2MEM_DATA_W-1:0] rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic queue_traffic(input int p, input int count);
    logic                     idle;
    logic                     cmd_bit;
    logic [`L2MEM_ADDR_W-1:0] addr;
    logic [`L2MEM_TAG_W-1:0]  tag;
    logic [`L2MEM_DATA_W-1:0] data;
    logic [`L2MEM_BE_W-1:0]   be;
    for (int n = 0; n < count; n++) begin
      idle    = (($random(seed) & 3) == 3);
      cmd_bit = 1'($random(seed));
      addr    = line_addr($random(seed) & (N_FILL - 1));
      tag     = `L2MEM_TAG_W'($random(seed));
      data    = rand_data();
      be      = `L2MEM_BE_W'($random(seed));
      stim_q[p].push_back({idle, cmd_bit, addr, tag, data, be});
    end
  endtask

  task automatic random_traffic(input int p);
    logic                     idle;
    logic                     cmd_bit;
    logic [`L2MEM_ADDR_W-1:0] addr;
    logic [`L2MEM_TAG_W-1:0]  tag;
    logic [`L2MEM_DATA_W-1:0] data;
    logic [`L2MEM_BE_W-1:0]   be;
    while (stim_q[p].size() != 0) begin
      {idle, cmd_bit, addr, tag, data, be} = stim_q[p].pop_front();
      if (idle) begin
        @(posedge i_clk);
        #1;
      end
      send_req(p, mem_cmd_t'(cmd_bit), addr, tag, data, be);
    end
  endtask

  task automatic wait_drain();
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) @(posedge i_clk);
    repeat (2) @(posedge i_clk);
    #1;
  endtask

  initial begin
    ic_req_valid    = 1'b0;
    dc_req_valid    = 1'b0;
    ic_req_cmd      = M_XRD;
    dc_req_cmd      = M_XRD;
    ic_req_addr     = '0;
    dc_req_addr     = '0;
    ic_req_tag      = '0;
    dc_req_tag      = '0;
    ic_req_data     = '0;
    dc_req_data     = '0;
    ic_req_byte_en  = '0;
    dc_req_byte_en  = '0;
    ic_resp_ready   = 1'b1;
    dc_resp_ready   = 1'b1;
    wb_cyc          = 1'b0;
    wb_stb          = 1'b0;
    wb_we           = 1'b0;
    wb_adr          = '0;
    wb_dat          = '0;
    cycle           = 0;
    ack_count       = 0;
    check_latency   = 1'b0;
    bp_random       = 1'b0;
    expect_disabled = 1'b0;
    last_was_ic     = 1'b0;
    prev_stall      = '{1'b0, 1'b0};
    base_model      = `L2MEM_RESET_BASE;
    i_reset_n       = 1'b0;
    repeat (5) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;

    // Registers after reset, and no traffic while disabled
    reg_check("reset_ctrl", REG_CTRL, 32'h0);
    reg_check("reset_base", REG_BASE, `L2MEM_RESET_BASE);
    reg_check("reset_err_cnt", REG_ERR_CNT, 32'h0);
    expect_disabled = 1'b1;
    ic_req_valid    = 1'b1;
    dc_req_valid    = 1'b1;
    repeat (N_IDLE) @(posedge i_clk);
    #1;
    ic_req_valid    = 1'b0;
    dc_req_valid    = 1'b0;
    expect_disabled = 1'b0;
    reg_write(REG_BASE, 32'h4000_0000);
    reg_check("base_readback", REG_BASE, 32'h4000_0000);
    reg_write(REG_CTRL, 32'h1);
    reg_check("ctrl_readback", REG_CTRL, 32'h1);

    // Fill the working lines, then merge random byte enables
    for (int l = 0; l < N_FILL; l++) begin
      send_req(l & 1, M_XWR, line_addr(l), '0, rand_data(), '1);
    end
    for (int n = 0; n < N_FILL; n++) begin
      send_req(n & 1, M_XWR, line_addr($random(seed) & (N_FILL - 1)), '0, rand_data(),
               `L2MEM_BE_W'($random(seed)));
    end
    for (int l = 0; l < N_FILL; l++) begin
      send_req(l & 1, M_XRD, line_addr(l), `L2MEM_TAG_W'(l), '0, '0);
    end
    wait_drain();

    // Fixed latency with back-to-back reads
    check_latency = 1'b1;
    for (int n = 0; n < N_LAT; n++) begin
      send_req(0, M_XRD, line_addr(n % N_FILL), `L2MEM_TAG_W'(n), '0, '0);
    end
    wait_drain();
    check_latency = 1'b0;

    // Random back-pressure on a single port
    bp_random = 1'b1;
    for (int n = 0; n < N_BP; n++) begin
      send_req(1, M_XRD, line_addr(n % N_FILL), `L2MEM_TAG_W'(n), '0, '0);
    end
    wait_drain();

    // Both ports at once, with each port's stream drawn before either starts
    queue_traffic(0, N_RAND);
    queue_traffic(1, N_RAND);
    fork
      random_traffic(0);
      random_traffic(1);
    join
    wait_drain();
    bp_random = 1'b0;

    // Out-of-region requests
    reg_write(REG_ERR_CNT, 32'h0);
    send_req(0, M_XRD, base_model - 8, 4'h3, '0, '0);
    send_req(1, M_XWR, line_addr(`L2MEM_LINES), '0, rand_data(), '1);
    send_req(1, M_XRD, line_addr(`L2MEM_LINES + 5), 4'h9, '0, '0);
    send_req(0, M_XRD, line_addr(0), 4'h1, '0, '0);
    wait_drain();
    reg_check("err_cnt", REG_ERR_CNT, 32'd3);
    reg_check("err_addr", REG_ERR_ADDR, line_addr(`L2MEM_LINES + 5));
    reg_write(REG_ERR_CNT, 32'h5);
    reg_check("err_cnt_clear", REG_ERR_CNT, 32'h0);

    $display("Regression passed");
    $finish;
  end

endmodule

//--- l2mem_top.sv
`timescale 1ns/1ps
`include "l2mem_params.svh"

module l2mem_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_ic_req_valid,
  input  l2mem_pkg::mem_cmd_t      i_ic_req_cmd,
  input  logic [`L2MEM_ADDR_W-1:0] i_ic_req_addr,
  input  logic [`L2MEM_TAG_W-1:0]  i_ic_req_tag,
  input  logic [`L2MEM_DATA_W-1:0] i_ic_req_data,
  input  logic [`L2MEM_BE_W-1:0]   i_ic_req_byte_en,
  output logic                     o_ic_req_ready,
  output logic                     o_ic_resp_valid,
  output logic [`L2MEM_TAG_W-1:0]  o_ic_resp_tag,
  output logic [`L2MEM_DATA_W-1:0] o_ic_resp_data,
  output logic                     o_ic_resp_err,
  input  logic                     i_ic_resp_ready,

  input  logic                     i_dc_req_valid,
  input  l2mem_pkg::mem_cmd_t      i_dc_req_cmd,
  input  logic [`L2MEM_ADDR_W-1:0] i_dc_req_addr,
  input  logic [`L2MEM_TAG_W-1:0]  i_dc_req_tag,
  input  logic [`L2MEM_DATA_W-1:0] i_dc_req_data,
  input  logic [`L2MEM_BE_W-1:0]   i_dc_req_byte_en,
  output logic                     o_dc_req_ready,
  output logic                     o_dc_resp_valid,
  output logic [`L2MEM_TAG_W-1:0]  o_dc_resp_tag,
  output logic [`L2MEM_DATA_W-1:0] o_dc_resp_data,
  output logic                     o_dc_resp_err,
  input  logic                     i_dc_resp_ready,

  // Wishbone classic register slave
  input  logic                     i_wb_cyc,
  input  logic                     i_wb_stb,
  input  logic                     i_wb_we,
  input  logic [1:0]               i_wb_adr,
  input  logic [31:0]              i_wb_dat,
  output logic [31:0]              o_wb_dat,
  output logic                     o_wb_ack
);

  import l2mem_pkg::*;

  logic                     enable;
  logic [`L2MEM_ADDR_W-1:0] base;
  logic                     err_pulse;
  logic [`L2MEM_ADDR_W-1:0] err_addr;

  logic                     ram_req_valid;
  mem_cmd_t                 ram_req_cmd;
  logic [`L2MEM_LINE_W-1:0] ram_req_line;
  logic [`L2MEM_XTAG_W-1:0] ram_req_tag;
  logic                     ram_req_err;
  logic [`L2MEM_DATA_W-1:0] ram_req_data;
  logic [`L2MEM_BE_W-1:0]   ram_req_byte_en;
  logic                     ram_req_ready;
  logic                     ram_resp_valid;
  logic [`L2MEM_XTAG_W-1:0] ram_resp_tag;
  logic [`L2MEM_DATA_W-1:0] ram_resp_data;
  logic                     ram_resp_err;
  logic                     ram_resp_ready;

  // Bus and clock ports match by name
  l2mem_cfg_regs u_cfg_regs (
    .*,
    .i_err_pulse (err_pulse),
    .i_err_addr  (err_addr),
    .o_enable    (enable),
    .o_base      (base)
  );

  // Port channels match by name, RAM side is wired explicitly
  l2mem_port_mux u_port_mux (
    .*,
    .i_enable          (enable),
    .i_base            (base),
    .o_ram_req_valid   (ram_req_valid),
    .o_ram_req_cmd     (ram_req_cmd),
    .o_ram_req_line    (ram_req_line),
    .o_ram_req_tag     (ram_req_tag),
    .o_ram_req_err     (ram_req_err),
    .o_ram_req_data    (ram_req_data),
    .o_ram_req_byte_en (ram_req_byte_en),
    .i_ram_req_ready   (ram_req_ready),
    .i_ram_resp_valid  (ram_resp_valid),
    .i_ram_resp_tag    (ram_resp_tag),
    .i_ram_resp_data   (ram_resp_data),
    .i_ram_resp_err    (ram_resp_err),
    .o_ram_resp_ready  (ram_resp_ready),
    .o_err_pulse       (err_pulse),
    .o_err_addr        (err_addr)
  );

  l2mem_line_ram u_line_ram (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req_valid   (ram_req_valid),
    .i_req_cmd     (ram_req_cmd),
    .i_req_line    (ram_req_line),
    .i_req_tag     (ram_req_tag),
    .i_req_err     (ram_req_err),
    .i_req_data    (ram_req_data),
    .i_req_byte_en (ram_req_byte_en),
    .o_req_ready   (ram_req_ready),
    .o_resp_valid  (ram_resp_valid),
    .o_resp_tag    (ram_resp_tag),
    .o_resp_data   (ram_resp_data),
    .o_resp_err    (ram_resp_err),
    .i_resp_ready  (ram_resp_ready)
  );

endmodule

//--- l2mem_cfg_regs.sv
`timescale 1ns/1ps
`include "l2mem_params.svh"

module l2mem_cfg_regs (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_wb_cyc,
  input  logic                     i_wb_stb,
  input  logic                     i_wb_we,
  input  logic [1:0]               i_wb_adr,
  input  logic [31:0]              i_wb_dat,
  output logic [31:0]              o_wb_dat,
  output logic                     o_wb_ack,
  input  logic                     i_err_pulse,
  input  logic [`L2MEM_ADDR_W-1:0] i_err_addr,
  output logic                     o_enable,
  output logic [`L2MEM_ADDR_W-1:0] o_base
);

  import l2mem_pkg::*;

  typedef logic [`L2MEM_ADDR_W-1:0] addr_t;

  reg_addr_t   wb_reg;
  logic        wb_req;
  logic        wb_wr;
  logic        enable_q;
  addr_t       base_q;
  logic [31:0] err_cnt_q;
  addr_t       err_addr_q;
  logic [31:0] rd_data;

  assign wb_reg = reg_addr_t'(i_wb_adr);
  // A new access starts only while no ack is pending
  assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;
  assign wb_wr  = wb_req & i_wb_we;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wb_ack <= 1'b0;
      o_wb_dat <= '0;
    end else begin
      o_wb_ack <= wb_req;
      if (wb_req && !i_wb_we) begin
        o_wb_dat <= rd_data;
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (wb_reg)
      REG_CTRL:     rd_data = {31'b0, enable_q};
      REG_BASE:     rd_data = 32'(base_q);
      REG_ERR_CNT:  rd_data = err_cnt_q;
      REG_ERR_ADDR: rd_data = 32'(err_addr_q);
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      enable_q <= 1'b0;
      base_q   <= addr_t'(`L2MEM_RESET_BASE);
    end else if (wb_wr) begin
      if (wb_reg == REG_CTRL) begin
        enable_q <= i_wb_dat[0];
      end
      if (wb_reg == REG_BASE) begin
        base_q <= addr_t'(i_wb_dat);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      err_cnt_q  <= '0;
      err_addr_q <= '0;
    end else begin
      // Clearing write still counts an error arriving in the same cycle
      if (wb_wr && wb_reg == REG_ERR_CNT) begin
        err_cnt_q <= {31'b0, i_err_pulse};
      end else if (i_err_pulse && err_cnt_q != '1) begin
        err_cnt_q <= err_cnt_q + 32'd1;
      end
      if (i_err_pulse) begin
        err_addr_q <= i_err_addr;
      end
    end
  end

  assign o_enable = enable_q;
  assign o_base   = base_q;

endmodule

//--- l2mem_port_mux.sv
`timescale 1ns/1ps
`include "l2mem_params.svh"

module l2mem_port_mux (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_enable,
  input  logic [`L2MEM_ADDR_W-1:0] i_base,

  // Instruction-cache port
  input  logic                     i_ic_req_valid,
  input  l2mem_pkg::mem_cmd_t      i_ic_req_cmd,
  input  logic [`L2MEM_ADDR_W-1:0] i_ic_req_addr,
  input  logic [`L2MEM_TAG_W-1:0]  i_ic_req_tag,
  input  logic [`L2MEM_DATA_W-1:0] i_ic_req_data,
  input  logic [`L2MEM_BE_W-1:0]   i_ic_req_byte_en,
  output logic                     o_ic_req_ready,
  output logic                     o_ic_resp_valid,
  output logic [`L2MEM_TAG_W-1:0]  o_ic_resp_tag,
  output logic [`L2MEM_DATA_W-1:0] o_ic_resp_data,
  output logic                     o_ic_resp_err,
  input  logic                     i_ic_resp_ready,

  // Data-cache port
  input  logic                     i_dc_req_valid,
  input  l2mem_pkg::mem_cmd_t      i_dc_req_cmd,
  input  logic [`L2MEM_ADDR_W-1:0] i_dc_req_addr,
  input  logic [`L2MEM_TAG_W-1:0]  i_dc_req_tag,
  input  logic [`L2MEM_DATA_W-1:0] i_dc_req_data,
  input  logic [`L2MEM_BE_W-1:0]   i_dc_req_byte_en,
  output logic                     o_dc_req_ready,
  output logic                     o_dc_resp_valid,
  output logic [`L2MEM_TAG_W-1:0]  o_dc_resp_tag,
  output logic [`L2MEM_DATA_W-1:0] o_dc_resp_data,
  output logic                     o_dc_resp_err,
  input  logic                     i_dc_resp_ready,

  // Line RAM side
  output logic                     o_ram_req_valid,
  output l2mem_pkg::mem_cmd_t      o_ram_req_cmd,
  output logic [`L2MEM_LINE_W-1:0] o_ram_req_line,
  output logic [`L2MEM_XTAG_W-1:0] o_ram_req_tag,
  output logic                     o_ram_req_err,
  output logic [`L2MEM_DATA_W-1:0] o_ram_req_data,
  output logic [`L2MEM_BE_W-1:0]   o_ram_req_byte_en,
  input  logic                     i_ram_req_ready,
  input  logic                     i_ram_resp_valid,
  input  logic [`L2MEM_XTAG_W-1:0] i_ram_resp_tag,
  input  logic [`L2MEM_DATA_W-1:0] i_ram_resp_data,
  input  logic                     i_ram_resp_err,
  output logic                     o_ram_resp_ready,

  output logic                     o_err_pulse,
  output logic [`L2MEM_ADDR_W-1:0] o_err_addr
);

  localparam int OFFS_W = $clog2(`L2MEM_BE_W);

  logic                     rr_dc;
  logic                     grant_ic;
  logic                     grant_dc;
  logic                     req_fire;
  logic [`L2MEM_ADDR_W-1:0] sel_addr;
  logic [`L2MEM_ADDR_W-1:0] offset;
  logic [`L2MEM_ADDR_W-1:0] line_pos;
  logic                     out_of_region;
  logic                     resp_src;

  // Pointer only decides when both ports ask at once
  assign grant_ic = i_ic_req_valid & (~i_dc_req_valid | ~rr_dc);
  assign grant_dc = i_dc_req_valid & (~i_ic_req_valid | rr_dc);

  assign o_ic_req_ready = i_enable & i_ram_req_ready & grant_ic;
  assign o_dc_req_ready = i_enable & i_ram_req_ready & grant_dc;

  assign o_ram_req_valid = i_enable & (grant_ic | grant_dc);
  assign req_fire        = o_ram_req_valid & i_ram_req_ready;

  // After a grant the other port gets priority
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      rr_dc <= 1'b0;
    end else if (req_fire) begin
      rr_dc <= grant_ic;
    end
  end

  assign sel_addr = grant_dc ? i_dc_req_addr : i_ic_req_addr;
  assign offset   = sel_addr - i_base;
  assign line_pos = offset >> OFFS_W;
  // Below the base the subtraction wraps, so check that case on its own
  assign out_of_region = (sel_addr < i_base) || (line_pos >= `L2MEM_LINES);

  assign o_ram_req_cmd     = grant_dc ? i_dc_req_cmd : i_ic_req_cmd;
  assign o_ram_req_line    = line_pos[`L2MEM_LINE_W-1:0];
  assign o_ram_req_tag     = grant_dc ? {1'b1, i_dc_req_tag} : {1'b0, i_ic_req_tag};
  assign o_ram_req_err     = out_of_region;
  assign o_ram_req_data    = grant_dc ? i_dc_req_data : i_ic_req_data;
  assign o_ram_req_byte_en = grant_dc ? i_dc_req_byte_en : i_ic_req_byte_en;

  assign o_err_pulse = req_fire & out_of_region;
  assign o_err_addr  = sel_addr;

  // Top tag bit names the port that owns the response
  assign resp_src = i_ram_resp_tag[`L2MEM_TAG_W];

  assign o_ic_resp_valid = i_ram_resp_valid & ~resp_src;
  assign o_ic_resp_tag   = i_ram_resp_tag[`L2MEM_TAG_W-1:0];
  assign o_ic_resp_data  = i_ram_resp_data;
  assign o_ic_resp_err   = i_ram_resp_err;

  assign o_dc_resp_valid = i_ram_resp_valid & resp_src;
  assign o_dc_resp_tag   = i_ram_resp_tag[`L2MEM_TAG_W-1:0];
  assign o_dc_resp_data  = i_ram_resp_data;
  assign o_dc_resp_err   = i_ram_resp_err;

  assign o_ram_resp_ready = resp_src ? i_dc_resp_ready : i_ic_resp_ready;

endmodule

//--- l2mem_line_ram.sv
`timescale 1ns/1ps
`include "l2mem_params.svh"

module l2mem_line_ram (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_req_valid,
  input  l2mem_pkg::mem_cmd_t      i_req_cmd,
  input  logic [`L2MEM_LINE_W-1:0] i_req_line,
  input  logic [`L2MEM_XTAG_W-1:0] i_req_tag,
  input  logic                     i_req_err,
  input  logic [`L2MEM_DATA_W-1:0] i_req_data,
  input  logic [`L2MEM_BE_W-1:0]   i_req_byte_en,
  output logic                     o_req_ready,
  output logic                     o_resp_valid,
  output logic [`L2MEM_XTAG_W-1:0] o_resp_tag,
  output logic [`L2MEM_DATA_W-1:0] o_resp_data,
  output logic                     o_resp_err,
  input  logic                     i_resp_ready
);

  import l2mem_pkg::*;

  localparam int LAT = `L2MEM_RD_LAT;

  logic [`L2MEM_DATA_W-1:0] mem [`L2MEM_LINES];

  logic                     stall;
  logic                     req_fire;
  logic                     rd_fire;
  logic                     wr_fire;
  logic [LAT-1:0]           rd_valid;
  logic [`L2MEM_XTAG_W-1:0] rd_tag  [LAT];
  logic [`L2MEM_DATA_W-1:0] rd_data [LAT];
  logic                     rd_err  [LAT];

  // Whole pipeline holds while the oldest response waits
  assign stall       = rd_valid[LAT-1] & ~i_resp_ready;
  assign o_req_ready = ~stall;
  assign req_fire    = i_req_valid & o_req_ready;
  assign rd_fire     = req_fire & (i_req_cmd == M_XRD);
  // Out-of-region writes never touch the array
  assign wr_fire     = req_fire & (i_req_cmd == M_XWR) & ~i_req_err;

  always_ff @(posedge i_clk) begin
    if (wr_fire) begin
      for (int b = 0; b < `L2MEM_BE_W; b++) begin
        if (i_req_byte_en[b]) begin
          mem[i_req_line][b*8 +: 8] <= i_req_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      rd_valid <= '0;
    end else if (!stall) begin
      rd_valid[0] <= rd_fire;
      for (int i = 1; i < LAT; i++) begin
        rd_valid[i] <= rd_valid[i-1];
      end
    end
  end

  // Stage 0 samples the array at acceptance, so earlier writes are visible
  always_ff @(posedge i_clk) begin
    if (!stall) begin
      rd_tag[0]  <= i_req_tag;
      rd_err[0]  <= i_req_err;
      rd_data[0] <= i_req_err ? '0 : mem[i_req_line];
      for (int i = 1; i < LAT; i++) begin
        rd_tag[i]  <= rd_tag[i-1];
        rd_err[i]  <= rd_err[i-1];
        rd_data[i] <= rd_data[i-1];
      end
    end
  end

  assign o_resp_valid = rd_valid[LAT-1];
  assign o_resp_tag   = rd_tag[LAT-1];
  assign o_resp_data  = rd_data[LAT-1];
  assign o_resp_err   = rd_err[LAT-1];

endmodule

//--- l2mem_pkg.sv
package l2mem_pkg;

  // Command carried with every line request
  typedef enum logic [0:0] {
    M_XRD = 1'b0,
    M_XWR = 1'b1
  } mem_cmd_t;

  // Word index on the register bus
  typedef enum logic [1:0] {
    REG_CTRL     = 2'd0,
    REG_BASE     = 2'd1,
    REG_ERR_CNT  = 2'd2,
    REG_ERR_ADDR = 2'd3
  } reg_addr_t;

endpackage

//--- l2mem_params.svh
`ifndef L2MEM_PARAMS_SVH
`define L2MEM_PARAMS_SVH

// Line width in bits, one byte enable per byte
`define L2MEM_DATA_W 64
`define L2MEM_BE_W (`L2MEM_DATA_W / 8)

// Request address and requester tag
`define L2MEM_ADDR_W 32
`define L2MEM_TAG_W 4
// Tag with the source bit on top
`define L2MEM_XTAG_W (`L2MEM_TAG_W + 1)

// Line array
`define L2MEM_LINES 256
`define L2MEM_LINE_W $clog2(`L2MEM_LINES)

`define L2MEM_RD_LAT 4
`define L2MEM_RESET_BASE 32'h8000_0000

`endif
